// File: aud_pkg.sv
// Shared widths, sample and frame types, and serializer constants for the
// audio output path. Modules import it with a wildcard inside their body.

package aud_pkg;

  ////////////////////
  // Samples
  ////////////////////

  localparam int SAMPLE_W = 15;                      // Signed DAC sample width

  typedef logic signed [SAMPLE_W-1:0] sample_t;      // One channel sample

  typedef struct packed {
    sample_t left;                                   // Left channel, upper bits
    sample_t right;                                  // Right channel
  } aud_frame_t;

  ////////////////////
  // Frame buffer
  ////////////////////

  localparam int FIFO_DEPTH = 4;                     // Frames held, also start credits
  localparam int PTR_W      = $clog2(FIFO_DEPTH);    // Index width
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1); // Holds 0..FIFO_DEPTH

  typedef logic [PTR_W-1:0] fifo_ptr_t;              // Read / write index
  typedef logic [CNT_W-1:0] fifo_cnt_t;              // Occupancy

  ////////////////////
  // Serializer
  ////////////////////

  localparam int BCLK_HALF = 2;                      // clk_28 cycles per bclk half
  localparam int HCNT_W    = (BCLK_HALF > 1) ? $clog2(BCLK_HALF) : 1;
  localparam int SLOT_BITS = 16;                     // bclk periods per channel slot
  localparam int PAD_BITS  = SLOT_BITS - SAMPLE_W;   // Zero bits after the LSB
  localparam int BIT_W     = $clog2(SLOT_BITS);
  localparam int SHIFT_W   = 2 * SLOT_BITS;          // Both slots of one frame

  typedef logic [HCNT_W-1:0]  half_cnt_t;            // Position in a bclk half
  typedef logic [BIT_W-1:0]   bit_cnt_t;             // Bit index inside a slot
  typedef logic [SHIFT_W-1:0] shift_reg_t;           // Left slot then right slot

  typedef enum logic {
    ST_LEFT  = 1'b0,                                 // lrck low
    ST_RIGHT = 1'b1                                  // lrck high
  } shift_state_t;

endpackage

// File: aud_frame_fifo.sv
// Credit-managed frame buffer at the audio input. The source spends one credit
// per in_valid cycle and gets one back on credit_return as each frame leaves.

`timescale 1ns/1ns

module aud_frame_fifo (
  input  logic                clk_28,         // Audio pipeline clock
  input  logic                rst,            // Sync reset, active high
  input  logic                in_valid,       // One frame, one credit
  input  aud_pkg::aud_frame_t in_frame,       // Frame from chipset side
  output logic                fifo_valid,     // Buffer not empty
  output aud_pkg::aud_frame_t fifo_frame,     // Oldest frame
  input  logic                fifo_ready,     // Mix stage can take it
  output logic                credit_return   // One pulse per frame out
);

  import aud_pkg::*;

  aud_frame_t mem [FIFO_DEPTH];               // Frame storage
  fifo_ptr_t  wr_ptr;                         // Next free entry
  fifo_ptr_t  rd_ptr;                         // Oldest entry
  fifo_cnt_t  cnt;                            // Frames held
  logic       push;
  logic       pop;

  // Circular increment, also correct for depths that are not a power of two
  function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t ptr);
    fifo_ptr_t nxt;
    if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  ////////////////////
  // Handshake
  ////////////////////

  assign push          = in_valid;                   // Credits keep a slot free
  assign fifo_valid    = (cnt != '0);                // Visible the cycle after a write
  assign pop           = fifo_valid & fifo_ready;    // Frame moves to mix stage
  assign fifo_frame    = mem[rd_ptr];                // Head of buffer
  assign credit_return = pop;                        // Same cycle as transfer out

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_28) begin
    if (push) begin
      mem[wr_ptr] <= in_frame;                       // No full check needed
    end
  end

  ////////////////////
  // Pointers, count
  ////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  always_ff @(posedge clk_28) begin
    if (rst) begin
      cnt <= '0;                                     // Empty after reset
    end else begin
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;                  // Write only
        2'b01:   cnt <= cnt - 1'b1;                  // Read only
        default: cnt <= cnt;                         // Both or neither
      endcase
    end
  end

endmodule

// File: aud_chan_mix.sv
// Channel stage between the frame buffer and the serializer. Applies the
// board switches for channel exchange and centered mix, one frame register.

`timescale 1ns/1ns

module aud_chan_mix (
  input  logic                clk_28,         // Audio pipeline clock
  input  logic                rst,            // Sync reset, active high
  input  logic                exchan,         // Async switch, swap L/R
  input  logic                mix,            // Async switch, centered mix
  input  logic                fifo_valid,     // Frame offered by buffer
  input  aud_pkg::aud_frame_t fifo_frame,
  output logic                fifo_ready,     // Register free this cycle
  output logic                mix_valid,      // Output register full
  output aud_pkg::aud_frame_t mix_frame,      // Processed frame
  input  logic                mix_ready       // Shifter takes it
);

  import aud_pkg::*;

  logic [1:0] sw_meta;                        // {exchan, mix}, first flop
  logic [1:0] sw_sync;                        // Second flop, safe to use
  logic       exchan_s;
  logic       mix_s;
  logic       take;                           // Frame accepted this cycle
  aud_frame_t swapped;                        // After optional exchange
  aud_frame_t mixed;                          // After optional mix

  // Own/2 + own/4 + other/4, weights sum to one so 15 bits always hold it
  function automatic sample_t center(input sample_t own, input sample_t other);
    return (own >>> 1) + (own >>> 2) + (other >>> 2);
  endfunction

  ////////////////////
  // Switch sync
  ////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      sw_meta <= '0;
      sw_sync <= '0;
    end else begin
      sw_meta <= {exchan, mix};                      // May go metastable
      sw_sync <= sw_meta;
    end
  end

  assign exchan_s = sw_sync[1];
  assign mix_s    = sw_sync[0];

  ////////////////////
  // Channel math
  ////////////////////

  assign swapped = exchan_s ? {fifo_frame.right, fifo_frame.left} : fifo_frame;

  always_comb begin
    mixed = swapped;                                 // Straight through by default
    if (mix_s) begin
      mixed.left  = center(swapped.left, swapped.right);
      mixed.right = center(swapped.right, swapped.left);
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  assign fifo_ready = ~mix_valid | mix_ready;        // Empty or emptied now
  assign take       = fifo_valid & fifo_ready;

  always_ff @(posedge clk_28) begin
    if (rst) begin
      mix_valid <= 1'b0;
    end else if (take) begin
      mix_valid <= 1'b1;                             // Refill, maybe same cycle as drain
    end else if (mix_ready) begin
      mix_valid <= 1'b0;                             // Drained, nothing behind
    end
  end

  always_ff @(posedge clk_28) begin
    if (take) begin
      mix_frame <= mixed;
    end
  end

endmodule

// File: aud_dac_shifter.sv
// Serial DAC interface toward the codec. Generates the bit clock and the
// left/right clock and shifts frames out left-justified, one per 128 cycles.

`timescale 1ns/1ns

module aud_dac_shifter (
  input  logic                clk_28,         // Audio pipeline clock
  input  logic                rst,            // Sync reset, active high
  input  logic                mix_valid,      // Frame ready at mix stage
  input  aud_pkg::aud_frame_t mix_frame,
  output logic                mix_ready,      // Left slot start strobe
  output logic                aud_bclk,       // Codec bit clock
  output logic                aud_daclrck,    // Low = left, high = right
  output logic                aud_dacdat      // Serial data, MSB first
);

  import aud_pkg::*;

  half_cnt_t    half_cnt;                     // Cycles into bclk half
  logic         half_end;                     // bclk toggles after this cycle
  logic         bclk_fall;                    // bclk goes low after this cycle
  logic         slot_end;                     // Last bit of a slot done
  bit_cnt_t     bit_cnt;                      // Bit inside current slot
  shift_state_t state;                        // Current slot
  shift_reg_t   shreg;                        // Left slot then right slot
  aud_frame_t   load_frame;                   // Frame or zeros on underrun

  ////////////////////
  // Bit clock
  ////////////////////

  assign half_end = (half_cnt == half_cnt_t'(BCLK_HALF - 1));

  always_ff @(posedge clk_28) begin
    if (rst) begin
      half_cnt <= '0;
      aud_bclk <= 1'b0;                              // Low after reset
    end else if (half_end) begin
      half_cnt <= '0;
      aud_bclk <= ~aud_bclk;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // data moves only on the falling edge, so it is stable at every rise
  assign bclk_fall = half_end & aud_bclk;
  assign slot_end  = bclk_fall & (bit_cnt == bit_cnt_t'(SLOT_BITS - 1));

  ////////////////////
  // Slot FSM
  ////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      state   <= ST_LEFT;                            // Left slot starts at once
      bit_cnt <= '0;
    end else if (bclk_fall) begin
      if (slot_end) begin
        bit_cnt <= '0;
        state   <= (state == ST_LEFT) ? ST_RIGHT : ST_LEFT;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign aud_daclrck = (state == ST_RIGHT);

  // One cycle per frame, at the fall that opens the next left slot
  assign mix_ready  = slot_end & (state == ST_RIGHT);
  assign load_frame = mix_valid ? mix_frame : '0;    // Underrun sends silence

  ////////////////////
  // Shift register
  ////////////////////

  always_ff @(posedge clk_28) begin
    if (rst) begin
      shreg <= '0;                                   // First slot is silent
    end else if (mix_ready) begin
      shreg <= {load_frame.left,  {PAD_BITS{1'b0}},
                load_frame.right, {PAD_BITS{1'b0}}};
    end else if (bclk_fall) begin
      shreg <= {shreg[SHIFT_W-2:0], 1'b0};           // Next bit to the MSB
    end
  end

  assign aud_dacdat = shreg[SHIFT_W-1];

endmodule

// File: aud_path_top.sv
// Top of the audio output path. Chains the credit buffer, the channel
// stage and the serial DAC shifter, all on clk_28.

`timescale 1ns/1ns

module aud_path_top (
  input  logic                clk_28,         // Audio pipeline clock
  input  logic                rst,            // Sync reset, active high
  // chipset side
  input  logic                in_valid,       // Frame strobe, costs a credit
  input  aud_pkg::aud_frame_t in_frame,       // Stereo sample pair
  output logic                credit_return,  // One credit back
  // board switches
  input  logic                exchan,         // Swap left / right
  input  logic                mix,            // Centered mix
  // codec
  output logic                aud_bclk,       // Bit clock
  output logic                aud_daclrck,    // Left/right clock
  output logic                aud_dacdat      // Serial data
);

  import aud_pkg::*;

  logic       fifo_valid;                     // Buffer to mix stage
  logic       fifo_ready;
  aud_frame_t fifo_frame;
  logic       mix_valid;                      // Mix stage to shifter
  logic       mix_ready;
  aud_frame_t mix_frame;

  ////////////////////
  // Pipeline
  ////////////////////

  aud_frame_fifo u_fifo (
    .clk_28        (clk_28        ),
    .rst           (rst           ),
    .in_valid      (in_valid      ),
    .in_frame      (in_frame      ),
    .fifo_valid    (fifo_valid    ),
    .fifo_frame    (fifo_frame    ),
    .fifo_ready    (fifo_ready    ),
    .credit_return (credit_return )   // Straight to the source
  );

  aud_chan_mix u_mix (
    .clk_28        (clk_28        ),
    .rst           (rst           ),
    .exchan        (exchan        ),  // Synchronized inside
    .mix           (mix           ),  // Synchronized inside
    .fifo_valid    (fifo_valid    ),
    .fifo_frame    (fifo_frame    ),
    .fifo_ready    (fifo_ready    ),
    .mix_valid     (mix_valid     ),
    .mix_frame     (mix_frame     ),
    .mix_ready     (mix_ready     )
  );

  aud_dac_shifter u_shift (
    .clk_28        (clk_28        ),
    .rst           (rst           ),
    .mix_valid     (mix_valid     ),
    .mix_frame     (mix_frame     ),
    .mix_ready     (mix_ready     ),  // Once per 128 cycles
    .aud_bclk      (aud_bclk      ),
    .aud_daclrck   (aud_daclrck   ),
    .aud_dacdat    (aud_dacdat    )
  );

endmodule

// File: tb_aud_path.sv
// Testbench for the audio output path. Sends credit-limited stereo frames,
// rebuilds the serial DAC stream and checks it against a queue of expected frames.

`timescale 1ns/1ns

module tb_aud_path;

  import aud_pkg::*;

  localparam int HALF_BCLK_CYC  = BCLK_HALF;                    // clk_28 cycles per bclk half
  localparam int BCLK_CYC       = 2 * HALF_BCLK_CYC;            // 4
  localparam int SLOT_CYC       = SLOT_BITS * BCLK_CYC;         // 64 cycles per lrck half
  localparam int FRAME_CYC      = 2 * SLOT_CYC;                 // 128
  localparam int TIMEOUT_CYCLES = 12 * FRAME_CYC * 5 + 2000;

  logic        clk_28;
  logic        rst;
  logic        in_valid;
  aud_frame_t  in_frame;
  logic        exchan;
  logic        mix;
  logic        credit_return;
  logic        aud_bclk;
  logic        aud_daclrck;
  logic        aud_dacdat;

  aud_frame_t  exp_q [$];                  // Frames still due at the codec
  logic [31:0] rnd_state;
  logic        sw_exchan;                  // Switch values the model applies
  logic        sw_mix;
  int          sent;                       // Frames pushed and credits spent
  int          returned;                   // credit_return pulses seen
  int          stalls;                     // Cycles spent waiting for a credit
  int          errors;
  int          checked;
  int          underruns;
  int          tests_run;
  int          tests_bad;
  int          cycles;

  logic        rst_q = 1'b0;               // Reset seen at the last edge
  logic        bclk_prev;
  logic        lrck_prev;
  logic        dat_prev;
  logic        rise_flag;                  // bclk rose at the last edge
  logic        lrck_flag;                  // lrck toggled at the last edge
  int          bclk_cnt;
  int          rise_gap;
  int          bclk_rises;
  int          lrck_cnt;
  int          lrck_gap;
  int          lrck_edges;

  logic                 slot_lrck;         // Slot being rebuilt
  int                   bit_idx;
  logic [SLOT_BITS-1:0] lbits;
  logic [SLOT_BITS-1:0] rbits;
  logic                 chk_valid;         // Rebuilt frame ready to compare
  aud_frame_t           chk_exp;
  aud_frame_t           chk_got;
  logic                 pad_valid;
  logic [1:0]           pad_bits;          // One pad bit per slot
  logic                 extra;             // Frame with nothing expected

  aud_path_top dut (
    .clk_28        (clk_28       ),
    .rst           (rst          ),
    .in_valid      (in_valid     ),
    .in_frame      (in_frame     ),
    .credit_return (credit_return),
    .exchan        (exchan       ),
    .mix           (mix          ),
    .aud_bclk      (aud_bclk     ),
    .aud_daclrck   (aud_daclrck  ),
    .aud_dacdat    (aud_dacdat   )
  );

  initial begin
    clk_28 = 1'b0;
    forever #10 clk_28 = ~clk_28;                    // 20 ns period
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Half of own plus a quarter of each channel as floor shifts on int
  function automatic sample_t centered_sample(input sample_t own, input sample_t other);
    int sum;
    sum = (int'(own) >>> 1) + (int'(own) >>> 2) + (int'(other) >>> 2);
    return sample_t'(sum);
  endfunction

  function automatic aud_frame_t expected_frame(input aud_frame_t fr, input logic ex,
                                                input logic mx);
    aud_frame_t s;
    aud_frame_t r;
    s = fr;
    if (ex) begin
      s.left  = fr.right;                            // Swap comes first
      s.right = fr.left;
    end
    r = s;
    if (mx) begin
      r.left  = centered_sample(s.left, s.right);
      r.right = centered_sample(s.right, s.left);
    end
    return r;
  endfunction

  ////////////////////
  // Monitors
  ////////////////////

  always @(posedge clk_28) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  always @(posedge clk_28) begin
    if (rst) begin
      returned <= 0;
    end else if (credit_return) begin
      returned <= returned + 1;                      // Credit usable from this edge
    end
  end

  always @(posedge clk_28) begin : clock_watch
    rst_q     <= rst;
    bclk_prev <= aud_bclk;
    lrck_prev <= aud_daclrck;
    dat_prev  <= aud_dacdat;
    rise_flag <= 1'b0;
    lrck_flag <= 1'b0;
    if (rst) begin
      bclk_cnt   <= 0;
      bclk_rises <= 0;
      lrck_cnt   <= 0;
      lrck_edges <= 0;
    end else begin
      if (aud_bclk && !bclk_prev) begin
        rise_gap   <= bclk_cnt + 1;                  // Edges since last rise
        rise_flag  <= 1'b1;
        bclk_cnt   <= 0;
        bclk_rises <= bclk_rises + 1;
      end else begin
        bclk_cnt <= bclk_cnt + 1;
      end
      if (aud_daclrck != lrck_prev) begin
        lrck_gap   <= lrck_cnt + 1;
        lrck_flag  <= 1'b1;
        lrck_cnt   <= 0;
        lrck_edges <= lrck_edges + 1;
      end else begin
        lrck_cnt <= lrck_cnt + 1;
      end
    end
  end

  // Rebuilds one frame per lrck period from the bits at each bclk rise
  always @(posedge clk_28) begin : slot_capture
    aud_frame_t got;
    chk_valid <= 1'b0;
    pad_valid <= 1'b0;
    extra     <= 1'b0;
    if (rst) begin
      slot_lrck = 1'b1;                              // First left slot opens a frame
      bit_idx   = 0;
    end else if (aud_bclk && !bclk_prev) begin
      if (aud_daclrck != slot_lrck) begin
        slot_lrck = aud_daclrck;
        bit_idx   = 0;
      end
      if (!aud_daclrck) begin
        lbits = {lbits[SLOT_BITS-2:0], aud_dacdat};  // MSB first
      end else begin
        rbits = {rbits[SLOT_BITS-2:0], aud_dacdat};
      end
      bit_idx++;
      if (aud_daclrck && bit_idx == SLOT_BITS) begin
        got.left  = lbits[SLOT_BITS-1 -: SAMPLE_W];
        got.right = rbits[SLOT_BITS-1 -: SAMPLE_W];
        pad_valid <= 1'b1;
        pad_bits  <= {lbits[0], rbits[0]};
        if (got == '0 && (exp_q.size() == 0 || exp_q[0] != '0)) begin
          underruns++;                               // Silence between bursts
        end else if (exp_q.size() == 0) begin
          extra <= 1'b1;
        end else begin
          chk_exp   <= exp_q.pop_front();
          chk_got   <= got;
          chk_valid <= 1'b1;
          checked++;
        end
      end
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_reset_low: assert property (@(posedge clk_28)
      rst_q |-> !(aud_bclk | aud_daclrck | aud_dacdat | credit_return))
    else begin
      $display("CHECK FAILED t=%0t reset outputs exp=0000 got=%b%b%b%b", $time,
               $sampled(aud_bclk), $sampled(aud_daclrck), $sampled(aud_dacdat),
               $sampled(credit_return));
      errors++;
    end

  a_bclk_period: assert property (@(posedge clk_28) disable iff (rst)
      (rise_flag && bclk_rises > 1) |-> rise_gap == BCLK_CYC)
    else begin
      $display("CHECK FAILED t=%0t aud_bclk period exp=%0d got=%0d", $time,
               BCLK_CYC, $sampled(rise_gap));
      errors++;
    end

  a_lrck_half: assert property (@(posedge clk_28) disable iff (rst)
      (lrck_flag && lrck_edges > 1) |-> lrck_gap == SLOT_CYC)
    else begin
      $display("CHECK FAILED t=%0t aud_daclrck half period exp=%0d got=%0d", $time,
               SLOT_CYC, $sampled(lrck_gap));
      errors++;
    end

  // Data may only move together with a falling bclk
  a_data_edge: assert property (@(posedge clk_28) disable iff (rst)
      (aud_dacdat == dat_prev) || (bclk_prev && !aud_bclk))
    else begin
      $display("CHECK FAILED t=%0t aud_dacdat off bclk fall exp=%b got=%b", $time,
               $sampled(dat_prev), $sampled(aud_dacdat));
      errors++;
    end

  a_pad_zero: assert property (@(posedge clk_28) disable iff (rst)
      pad_valid |-> pad_bits == 2'b00)
    else begin
      $display("CHECK FAILED t=%0t aud_dacdat pad bits exp=00 got=%b", $time,
               $sampled(pad_bits));
      errors++;
    end

  a_left: assert property (@(posedge clk_28) disable iff (rst)
      chk_valid |-> chk_got.left == chk_exp.left)
    else begin
      $display("CHECK FAILED t=%0t aud_dacdat left exp=%h got=%h", $time,
               $sampled(chk_exp.left), $sampled(chk_got.left));
      errors++;
    end

  a_right: assert property (@(posedge clk_28) disable iff (rst)
      chk_valid |-> chk_got.right == chk_exp.right)
    else begin
      $display("CHECK FAILED t=%0t aud_dacdat right exp=%h got=%h", $time,
               $sampled(chk_exp.right), $sampled(chk_got.right));
      errors++;
    end

  a_no_extra: assert property (@(posedge clk_28) disable iff (rst) !extra)
    else begin
      $display("a nonzero frame came out of the codec port with none expected");
      errors++;
    end

  // Buffer, mix register and shifter hold at most six frames
  a_in_flight: assert property (@(posedge clk_28) disable iff (rst)
      (sent - checked) <= FIFO_DEPTH + 2)
    else begin
      $display("CHECK FAILED t=%0t frames in flight exp<=%0d got=%0d", $time,
               FIFO_DEPTH + 2, $sampled(sent) - $sampled(checked));
      errors++;
    end

  a_credit_bound: assert property (@(posedge clk_28) disable iff (rst) returned <= sent)
    else begin
      $display("CHECK FAILED t=%0t credit_return total exp<=%0d got=%0d", $time,
               $sampled(sent), $sampled(returned));
      errors++;
    end

  ////////////////////
  // Stimulus tasks
  ////////////////////

  task automatic set_switches(input logic ex, input logic mx);
    @(posedge clk_28);
    #2;
    exchan    = ex;
    mix       = mx;
    sw_exchan = ex;
    sw_mix    = mx;
    repeat (3) @(posedge clk_28);                    // Through the two-flop sync
  endtask

  // Sends n frames with gap idle cycles between them and only with a credit
  task automatic send_frames(input int n, input int gap);
    int         k;
    int         gap_left;
    aud_frame_t fr;
    k        = 0;
    gap_left = 0;
    while (k < n) begin
      @(posedge clk_28);
      #2;
      in_valid = 1'b0;
      if (gap_left > 0) begin
        gap_left--;
      end else if (sent - returned < FIFO_DEPTH) begin
        rnd_state = next_random(rnd_state);
        fr.left   = rnd_state[14:0];
        fr.right  = rnd_state[30:16];
        in_frame  = fr;
        in_valid  = 1'b1;
        exp_q.push_back(expected_frame(fr, sw_exchan, sw_mix));
        sent++;
        k++;
        gap_left = gap;
      end else begin
        stalls++;                                    // Out of credits
      end
    end
    @(posedge clk_28);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk_28);
    end
    repeat (2) @(posedge clk_28);                    // Let the last compare land
    #2;
    a_credits_back: assert (sent == returned) else begin
      $display("CHECK FAILED t=%0t credit_return count exp=%0d got=%0d", $time,
               sent, returned);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : main
    int err0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_frame  = '0;
    exchan    = 1'b0;
    mix       = 1'b0;
    sw_exchan = 1'b0;
    sw_mix    = 1'b0;
    rnd_state = 32'h29cf4306;
    sent      = 0;
    stalls    = 0;
    errors    = 0;
    checked   = 0;
    underruns = 0;
    tests_run = 0;
    tests_bad = 0;
    cycles    = 0;
    repeat (16) @(posedge clk_28);
    #2;
    rst = 1'b0;

    err0 = errors;                                   // Reset values and clock rates
    repeat (300) @(posedge clk_28);
    a_clocks_run: assert (bclk_rises > 60 && lrck_edges >= 3) else begin
      $display("aud_bclk or aud_daclrck is not running after reset");
      errors++;
    end
    report_test("reset_clocks", err0);

    err0 = errors;
    set_switches(1'b0, 1'b0);
    send_frames(10, 0);
    wait_drained();
    report_test("pass_through", err0);

    err0 = errors;
    set_switches(1'b1, 1'b0);
    send_frames(6, 60);                              // Spaced but still faster than the drain
    wait_drained();
    report_test("exchange", err0);

    err0 = errors;
    set_switches(1'b0, 1'b1);
    send_frames(6, 0);
    wait_drained();
    set_switches(1'b1, 1'b1);                        // Swap then mix
    send_frames(6, 0);
    wait_drained();
    report_test("centered_mix", err0);

    err0   = errors;
    stalls = 0;
    set_switches(1'b0, 1'b0);
    send_frames(10, 0);
    wait_drained();
    a_backpressure: assert (stalls > 0) else begin
      $display("credits never ran out during the back-to-back burst");
      errors++;
    end
    report_test("credits", err0);

    $display("summary: %0d tests, %0d failed, %0d frames checked, %0d underruns, %0d errors",
             tests_run, tests_bad, checked, underruns, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
aud_pkg.sv
aud_frame_fifo.sv
aud_chan_mix.sv
aud_dac_shifter.sv
aud_path_top.sv
tb_aud_path.sv

// File: Bender.yml
# Audio output path: credit buffer, channel stage and serial DAC shifter

package:
  name: aud_path

dependencies: {}

sources:
  # Package first, then the stages, then the top level
  - aud_pkg.sv
  - aud_frame_fifo.sv
  - aud_chan_mix.sv
  - aud_dac_shifter.sv
  - aud_path_top.sv

  - target: simulation
    files:
      - tb_aud_path.sv
